//--- all.f
rtl/exec_isa_pkg.sv
rtl/exec_pipe_pkg.sv
rtl/operand_bypass.sv
rtl/branch_resolve.sv
rtl/lane_alu.sv
rtl/lane_multiplier.sv
rtl/execute_stage.sv
verification/execute_stage_sva.sv
verification/execute_stage_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -sv --top-module execute_stage_tb \
	-f all.f -o execute_stage_sim

./obj_dir/execute_stage_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "NO ERRORS" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi

//--- verification/execute_stage_tb.sv
`timescale 1ns/10ps

module execute_stage_tb
	import exec_isa_pkg::*, exec_pipe_pkg::*;
();

	localparam int NUM_LANES = 4;
	localparam int VAL_W = NUM_LANES * WORD_W;
	localparam int NUM_ISSUES = 400;
	localparam int DRAIN_LIMIT = 20;
	localparam logic [31:0] RANDOM_SEED = 32'h8658a1be;

	typedef struct packed {
		stage_result_t res;
		logic rollback;
		logic [WORD_W-1:0] rollback_pc;
		logic is_mul;
	} ref_out_t;

	logic clk;
	logic reset;
	logic valid_i;
	issue_t issue_i;
	logic [WORD_W-1:0] scalar1_i;
	logic [WORD_W-1:0] scalar2_i;
	lane_vec_t vector1_i;
	lane_vec_t vector2_i;
	bypass_t [NUM_BYPASS-1:0] bypass_i;
	logic result_valid_o;
	stage_result_t result_o;
	logic rollback_o;
	logic [WORD_W-1:0] rollback_pc_o;

	// Expected results, keyed by the checker cycle they are due in
	stage_result_t exp_by_cycle [int];
	int cyc = 0;

	execute_stage #(.NUM_LANES(NUM_LANES)) uut (
		.clk(clk),
		.reset(reset),
		.valid_i(valid_i),
		.issue_i(issue_i),
		.scalar1_i(scalar1_i),
		.scalar2_i(scalar2_i),
		.vector1_i(vector1_i),
		.vector2_i(vector2_i),
		.bypass_i(bypass_i),
		.result_valid_o(result_valid_o),
		.result_o(result_o),
		.rollback_o(rollback_o),
		.rollback_pc_o(rollback_pc_o)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic halt_on_failure();
		$display("ERRORS FOUND");
		$fatal(1, "Simulation stopped at the first failed check");
	endtask

	task automatic check_value(string name, logic [VAL_W-1:0] got, logic [VAL_W-1:0] expected);
		assert (got === expected)
		else
		begin
			$display("[FAIL] %0t ns %s expected %h got %h", $time, name, expected, got);
			halt_on_failure();
		end
	endtask

	// Mostly a few low registers so that bypass hits are common
	function automatic logic [REG_IDX_W-1:0] pick_reg();
		if ($urandom_range(7) == 0)
			return 5'(REG_PC);
		return 5'($urandom_range(3));
	endfunction

	// Small values, all ones and wide random values for branch and mask coverage
	function automatic logic [WORD_W-1:0] rand_word();
		case ($urandom_range(3))
			0: return 32'($urandom_range(3));
			1: return ($urandom_range(1) == 0) ? 32'hffff_ffff : 32'h0000_000f;
			default: return $urandom;
		endcase
	endfunction

	function automatic lane_vec_t rand_lanes();
		lane_vec_t v;
		for (int l = 0; l < NUM_LANES; l++)
			v[l] = rand_word();
		return v;
	endfunction

	function automatic bypass_t rand_bypass();
		bypass_t b;
		b.wb.has_writeback = 1'($urandom);
		b.wb.writeback_is_vector = 1'($urandom);
		b.wb.writeback_reg = 5'($urandom_range(3));
		b.value = rand_lanes();
		b.mask = NUM_LANES'($urandom);
		return b;
	endfunction

	function automatic issue_t rand_issue();
		issue_t iss;
		iss.strand = 2'($urandom);
		iss.pc = $urandom & 32'h0000_fffc;
		iss.alu_op = alu_op_e'(4'($urandom_range(12)));
		iss.branch = branch_e'(3'($urandom));
		iss.branch_offset = 20'($urandom);
		iss.branch_predicted = 1'($urandom);
		iss.op1_is_vector = 1'($urandom);
		iss.op2_src = op2_src_e'(2'($urandom_range(2)));
		iss.immediate = rand_word();
		iss.mask_src = mask_src_e'(3'($urandom_range(4)));
		iss.src1_reg = pick_reg();
		iss.src2_reg = pick_reg();
		iss.wb.has_writeback = ($urandom_range(3) != 0);
		iss.wb.writeback_is_vector = 1'($urandom);
		iss.wb.writeback_reg = pick_reg();
		return iss;
	endfunction

	function automatic logic tag_hit(wb_tag_t wb, logic [REG_IDX_W-1:0] src, logic vec);
		return wb.has_writeback && (wb.writeback_is_vector == vec) && (wb.writeback_reg == src);
	endfunction

	// Newest writer first: own result, memory access, writeback, post writeback
	function automatic logic [WORD_W-1:0] scalar_read(logic [REG_IDX_W-1:0] src,
		logic [WORD_W-1:0] pc, logic [WORD_W-1:0] rf, stage_result_t own,
		bypass_t [NUM_BYPASS-1:0] byp);
		if (src == 5'(REG_PC))
			return pc;
		if (tag_hit(own.wb, src, 1'b0))
			return own.result[0];
		for (int i = 0; i < NUM_BYPASS; i++)
		begin
			if (tag_hit(byp[i].wb, src, 1'b1 ^ 1'b1))
				return byp[i].value[0];
		end
		return rf;
	endfunction

	// Per lane, the newest writer whose mask covers that lane
	function automatic lane_vec_t vector_read(logic [REG_IDX_W-1:0] src, lane_vec_t rf,
		stage_result_t own, bypass_t [NUM_BYPASS-1:0] byp);
		lane_vec_t v;
		logic found;
		v = rf;
		for (int l = 0; l < NUM_LANES; l++)
		begin
			found = tag_hit(own.wb, src, 1'b1) && own.mask[l];
			if (found)
				v[l] = own.result[l];
			for (int i = 0; i < NUM_BYPASS; i++)
			begin
				if (!found && tag_hit(byp[i].wb, src, 1'b1) && byp[i].mask[l])
				begin
					v[l] = byp[i].value[l];
					found = 1'b1;
				end
			end
		end
		return v;
	endfunction

	function automatic ref_out_t exec_ref(issue_t iss, logic [WORD_W-1:0] s1_rf,
		logic [WORD_W-1:0] s2_rf, lane_vec_t v1_rf, lane_vec_t v2_rf,
		bypass_t [NUM_BYPASS-1:0] byp, stage_result_t own);
		ref_out_t r;
		logic [WORD_W-1:0] s1;
		logic [WORD_W-1:0] s2;
		logic [WORD_W-1:0] target;
		lane_vec_t v1;
		lane_vec_t v2;
		lane_vec_t a;
		lane_vec_t b;
		lane_vec_t alu;
		lane_mask_t flags;
		logic taken;
		s1 = scalar_read(iss.src1_reg, iss.pc, s1_rf, own, byp);
		s2 = scalar_read(iss.src2_reg, iss.pc, s2_rf, own, byp);
		v1 = vector_read(iss.src1_reg, v1_rf, own, byp);
		v2 = vector_read(iss.src2_reg, v2_rf, own, byp);
		flags = '0;
		for (int l = 0; l < NUM_LANES; l++)
		begin
			a[l] = iss.op1_is_vector ? v1[l] : s1;
			case (iss.op2_src)
				OP2_VECTOR2: b[l] = v2[l];
				OP2_IMMEDIATE: b[l] = iss.immediate;
				default: b[l] = s2;
			endcase
			alu[l] = '0;
			case (iss.alu_op)
				OP_ADD: alu[l] = a[l] + b[l];
				OP_SUB: alu[l] = a[l] - b[l];
				OP_AND: alu[l] = a[l] & b[l];
				OP_OR: alu[l] = a[l] | b[l];
				OP_XOR: alu[l] = a[l] ^ b[l];
				OP_SHL: alu[l] = a[l] << b[l][4:0];
				OP_SHR: alu[l] = a[l] >> b[l][4:0];
				OP_MUL: alu[l] = a[l] * b[l];
				OP_EQ: flags[l] = (a[l] == b[l]);
				OP_NE: flags[l] = (a[l] != b[l]);
				OP_SLT: flags[l] = ($signed(a[l]) < $signed(b[l]));
				OP_ULT: flags[l] = (a[l] < b[l]);
				OP_GE_U: flags[l] = (a[l] >= b[l]);
				default: alu[l] = '0;
			endcase
		end
		// One compare bit per lane, gathered in lane 0
		if (iss.alu_op inside {OP_EQ, OP_NE, OP_SLT, OP_ULT, OP_GE_U})
			alu[0][NUM_LANES-1:0] = flags;

		r.res.strand = iss.strand;
		r.res.pc = iss.pc;
		r.res.wb = iss.wb;
		case (iss.mask_src)
			MASK_SCALAR1: r.res.mask = s1[NUM_LANES-1:0];
			MASK_SCALAR1_INV: r.res.mask = ~s1[NUM_LANES-1:0];
			MASK_SCALAR2: r.res.mask = s2[NUM_LANES-1:0];
			MASK_SCALAR2_INV: r.res.mask = ~s2[NUM_LANES-1:0];
			default: r.res.mask = '1;
		endcase
		r.is_mul = (iss.alu_op == OP_MUL);
		r.res.result = alu;
		// Link value of a call
		if (!r.is_mul && (iss.branch inside {BR_CALL_OFFSET, BR_CALL_REGISTER}))
		begin
			r.res.result = '0;
			r.res.result[0] = iss.pc;
		end

		target = iss.pc + {{(WORD_W - BR_OFFSET_W){iss.branch_offset[BR_OFFSET_W-1]}},
			iss.branch_offset};
		case (iss.branch)
			BR_ZERO: taken = (a[0] == '0);
			BR_NOT_ZERO: taken = (a[0] != '0);
			BR_ALL: taken = &a[0][NUM_LANES-1:0];
			BR_NOT_ALL: taken = !(&a[0][NUM_LANES-1:0]);
			BR_ALWAYS, BR_CALL_OFFSET: taken = 1'b1;
			BR_CALL_REGISTER:
			begin
				taken = 1'b1;
				target = a[0];
			end
			default: taken = 1'b0;
		endcase
		// Scalar write to the PC register jumps to the ALU result
		if (iss.wb.has_writeback && !iss.wb.writeback_is_vector
			&& (iss.wb.writeback_reg == 5'(REG_PC)))
		begin
			taken = 1'b1;
			target = alu[0];
		end
		r.rollback = (taken != iss.branch_predicted);
		r.rollback_pc = taken ? target : iss.pc;
		return r;
	endfunction

	initial
	begin : drive_stimulus
		issue_t iss;
		logic go;
		logic [2:0] mul_hist;
		int waited;
		void'($urandom(RANDOM_SEED));
		reset = 1'b1;
		valid_i = 1'b0;
		issue_i = '0;
		scalar1_i = '0;
		scalar2_i = '0;
		vector1_i = '0;
		vector2_i = '0;
		bypass_i = '0;
		mul_hist = '0;
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		repeat (2) @(posedge clk);
		for (int n = 0; n < NUM_ISSUES; n++)
		begin
			iss = rand_issue();
			// Open with three back-to-back multiplies
			if (n < 3)
				iss.alu_op = OP_MUL;
			if (iss.alu_op == OP_MUL)
			begin
				iss.branch = BR_NONE;
				iss.wb.writeback_reg = 5'($urandom_range(3));
			end
			go = (n < 3) || ($urandom_range(9) < 8);
			// Leave the output register to a multiply in its last stage
			if (mul_hist[2] && (iss.alu_op != OP_MUL))
				go = 1'b0;
			mul_hist = {mul_hist[1:0], go && (iss.alu_op == OP_MUL)};
			valid_i <= go;
			issue_i <= iss;
			scalar1_i <= rand_word();
			scalar2_i <= rand_word();
			vector1_i <= rand_lanes();
			vector2_i <= rand_lanes();
			bypass_i <= {rand_bypass(), rand_bypass(), rand_bypass()};
			@(posedge clk);
		end
		valid_i <= 1'b0;
		waited = 0;
		while ((exp_by_cycle.num() != 0) && (waited < DRAIN_LIMIT))
		begin
			@(posedge clk);
			waited++;
		end
		if (exp_by_cycle.num() != 0)
		begin
			$display("Timed out waiting for %0d outstanding results", exp_by_cycle.num());
			halt_on_failure();
		end
		else
		begin
			$display("NO ERRORS");
			$finish;
		end
	end

	// Inputs settle after the rising edge, so compare on the falling edge
	always @(negedge clk)
	begin : compare_outputs
		ref_out_t expected;
		stage_result_t own_model;
		logic arriving;
		int due_cycle;
		cyc++;
		arriving = (exp_by_cycle.exists(cyc) != 0);
		check_value("result_valid_o", VAL_W'(result_valid_o), VAL_W'(arriving));
		// Model of the output register, which feeds the stage's own bypass
		own_model = '0;
		if (arriving)
		begin
			own_model = exp_by_cycle[cyc];
			exp_by_cycle.delete(cyc);
			check_value("result_o.strand", VAL_W'(result_o.strand), VAL_W'(own_model.strand));
			check_value("result_o.pc", VAL_W'(result_o.pc), VAL_W'(own_model.pc));
			check_value("result_o.wb", VAL_W'(result_o.wb), VAL_W'(own_model.wb));
			check_value("result_o.mask", VAL_W'(result_o.mask), VAL_W'(own_model.mask));
			check_value("result_o.result", result_o.result, own_model.result);
		end
		if (valid_i)
		begin
			expected = exec_ref(issue_i, scalar1_i, scalar2_i, vector1_i, vector2_i,
				bypass_i, own_model);
			check_value("rollback_o", VAL_W'(rollback_o), VAL_W'(expected.rollback));
			check_value("rollback_pc_o", VAL_W'(rollback_pc_o), VAL_W'(expected.rollback_pc));
			due_cycle = cyc + (expected.is_mul ? 4 : 1);
			assert (exp_by_cycle.exists(due_cycle) == 0)
			else
			begin
				$display("Two results are due in cycle %0d, the multiply hazard was hit",
					due_cycle);
				halt_on_failure();
			end
			exp_by_cycle[due_cycle] = expected.res;
		end
		else
			check_value("rollback_o", VAL_W'(rollback_o), '0);
	end

endmodule

//--- verification/execute_stage_sva.sv
`timescale 1ns/10ps

module execute_stage_sva
(
	input logic clk,
	input logic reset,
	input logic valid_i,
	input logic is_mul_i,
	input logic mul_done_i,
	input logic result_valid_i,
	input logic rollback_i
);

	// A finishing multiply owns the output register
	no_merge_hazard: assert property (
		@(posedge clk) disable iff (reset)
		!(valid_i && !is_mul_i && mul_done_i)
	) else $error("Single-cycle instruction issued while a multiply finishes");

	// Control outputs and the last multiplier stage stay low in reset
	quiet_in_reset: assert property (
		@(posedge clk) reset |-> (!result_valid_i && !rollback_i && !mul_done_i)
	) else $error("Control output active during reset");

	rollback_needs_valid: assert property (
		@(posedge clk) disable iff (reset)
		rollback_i |-> valid_i
	) else $error("Rollback raised without an issued instruction");

endmodule

bind execute_stage execute_stage_sva checks (
	.clk(clk),
	.reset(reset),
	.valid_i(valid_i),
	.is_mul_i(is_mul),
	.mul_done_i(mul_done),
	.result_valid_i(result_valid_o),
	.rollback_i(rollback_o)
);

//--- rtl/execute_stage.sv
`timescale 1ns/10ps

module execute_stage
	import exec_isa_pkg::*, exec_pipe_pkg::*;
#(
	parameter int NUM_LANES = LANES
)
(
	input logic clk,
	input logic reset,
	input logic valid_i,
	input issue_t issue_i,
	input logic [WORD_W-1:0] scalar1_i,
	input logic [WORD_W-1:0] scalar2_i,
	input logic [NUM_LANES-1:0][WORD_W-1:0] vector1_i,
	input logic [NUM_LANES-1:0][WORD_W-1:0] vector2_i,
	input bypass_t [NUM_BYPASS-1:0] bypass_i,
	output logic result_valid_o,
	output stage_result_t result_o,
	output logic rollback_o,
	output logic [WORD_W-1:0] rollback_pc_o
);

	logic [WORD_W-1:0] scalar1;
	logic [WORD_W-1:0] scalar2;
	logic [NUM_LANES-1:0][WORD_W-1:0] vector1;
	logic [NUM_LANES-1:0][WORD_W-1:0] vector2;
	logic [NUM_LANES-1:0][WORD_W-1:0] operand1;
	logic [NUM_LANES-1:0][WORD_W-1:0] operand2;
	logic [NUM_LANES-1:0][WORD_W-1:0] alu_result;
	logic [NUM_LANES-1:0][WORD_W-1:0] call_result;
	logic [NUM_LANES-1:0][WORD_W-1:0] mul_result;
	logic [NUM_LANES-1:0] lane_mask;
	logic is_mul;
	logic is_call;
	logic mul_done;
	mul_meta_t issue_meta;
	mul_meta_t mul_meta;
	logic valid_nxt;
	stage_result_t result_nxt;
	logic out_valid_q;
	stage_result_t out_data_q;

	assign is_mul = (issue_i.alu_op == OP_MUL);
	assign is_call = (issue_i.branch == BR_CALL_OFFSET) || (issue_i.branch == BR_CALL_REGISTER);

	operand_bypass #(.NUM_LANES(NUM_LANES)) bypass1 (
		.src_reg_i(issue_i.src1_reg),
		.pc_i(issue_i.pc),
		.scalar_i(scalar1_i),
		.vector_i(vector1_i),
		.own_i(result_o),
		.bypass_i(bypass_i),
		.is_vector_i(issue_i.op1_is_vector),
		.scalar_o(scalar1),
		.vector_o(vector1)
	);

	operand_bypass #(.NUM_LANES(NUM_LANES)) bypass2 (
		.src_reg_i(issue_i.src2_reg),
		.pc_i(issue_i.pc),
		.scalar_i(scalar2_i),
		.vector_i(vector2_i),
		.own_i(result_o),
		.bypass_i(bypass_i),
		.is_vector_i(issue_i.op2_src == OP2_VECTOR2),
		.scalar_o(scalar2),
		.vector_o(vector2)
	);

	assign operand1 = issue_i.op1_is_vector ? vector1 : {NUM_LANES{scalar1}};

	always_comb
	begin
		case (issue_i.op2_src)
			OP2_SCALAR2:   operand2 = {NUM_LANES{scalar2}};
			OP2_VECTOR2:   operand2 = vector2;
			OP2_IMMEDIATE: operand2 = {NUM_LANES{issue_i.immediate}};
			default:       operand2 = '0;
		endcase
	end

	// Lane mask comes from the low bits of a scalar
	always_comb
	begin
		case (issue_i.mask_src)
			MASK_SCALAR1:     lane_mask = scalar1[NUM_LANES-1:0];
			MASK_SCALAR1_INV: lane_mask = ~scalar1[NUM_LANES-1:0];
			MASK_SCALAR2:     lane_mask = scalar2[NUM_LANES-1:0];
			MASK_SCALAR2_INV: lane_mask = ~scalar2[NUM_LANES-1:0];
			default:          lane_mask = '1;
		endcase
	end

	lane_alu #(.NUM_LANES(NUM_LANES)) alu (
		.op_i(issue_i.alu_op),
		.a_i(operand1),
		.b_i(operand2),
		.result_o(alu_result)
	);

	branch_resolve branch (
		.valid_i(valid_i),
		.issue_i(issue_i),
		.op1_i(operand1),
		.alu_word_i(alu_result[0]),
		.taken_o(),
		.target_o(),
		.rollback_o(rollback_o),
		.rollback_pc_o(rollback_pc_o)
	);

	always_comb
	begin
		issue_meta.strand = issue_i.strand;
		issue_meta.pc = issue_i.pc;
		issue_meta.wb = issue_i.wb;
		issue_meta.mask = lane_mask;
	end

	lane_multiplier #(.NUM_LANES(NUM_LANES)) mul (
		.clk(clk),
		.reset(reset),
		.start_i(valid_i && is_mul),
		.a_i(operand1),
		.b_i(operand2),
		.meta_i(issue_meta),
		.done_o(mul_done),
		.result_o(mul_result),
		.meta_o(mul_meta)
	);

	// Link value of a call
	assign call_result = {{((NUM_LANES - 1) * WORD_W){1'b0}}, issue_i.pc};

	// A finishing multiply wins the merge of the two paths
	always_comb
	begin
		valid_nxt = 1'b0;
		result_nxt = '0;
		if (mul_done)
		begin
			valid_nxt = 1'b1;
			result_nxt.strand = mul_meta.strand;
			result_nxt.pc = mul_meta.pc;
			result_nxt.wb = mul_meta.wb;
			result_nxt.mask = mul_meta.mask;
			result_nxt.result = mul_result;
		end
		else if (valid_i && !is_mul)
		begin
			valid_nxt = 1'b1;
			result_nxt.strand = issue_i.strand;
			result_nxt.pc = issue_i.pc;
			result_nxt.wb = issue_i.wb;
			result_nxt.mask = lane_mask;
			result_nxt.result = is_call ? call_result : alu_result;
		end
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			out_valid_q <= 1'b0;
			out_data_q <= '0;
		end
		else
		begin
			out_valid_q <= valid_nxt;
			out_data_q <= result_nxt;
		end
	end

	assign result_o = out_data_q;
	assign result_valid_o = out_valid_q;

endmodule

//--- rtl/lane_multiplier.sv
`timescale 1ns/10ps

module lane_multiplier
	import exec_isa_pkg::*, exec_pipe_pkg::*;
#(
	parameter int NUM_LANES = LANES
)
(
	input logic clk,
	input logic reset,
	input logic start_i,
	input logic [NUM_LANES-1:0][WORD_W-1:0] a_i,
	input logic [NUM_LANES-1:0][WORD_W-1:0] b_i,
	input mul_meta_t meta_i,
	output logic done_o,
	output logic [NUM_LANES-1:0][WORD_W-1:0] result_o,
	output mul_meta_t meta_o
);

	logic [2:0] valid_q;
	mul_meta_t meta1_q;
	mul_meta_t meta2_q;
	mul_meta_t meta3_q;

	// Split on b: full a times low half, low half of a times high half
	logic [NUM_LANES-1:0][WORD_W-1:0] pp_lo_q;
	logic [NUM_LANES-1:0][15:0] pp_hi_q;
	logic [NUM_LANES-1:0][WORD_W-1:0] sum_q;
	logic [NUM_LANES-1:0][WORD_W-1:0] prod_q;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			valid_q <= '0;
		else
			valid_q <= {valid_q[1:0], start_i};
	end

	always_ff @(posedge clk)
	begin
		for (int l = 0; l < NUM_LANES; l++)
		begin
			pp_lo_q[l] <= a_i[l] * {16'd0, b_i[l][15:0]};
			pp_hi_q[l] <= a_i[l][15:0] * b_i[l][31:16];
			// Only the low 32 bits of the product are kept
			sum_q[l] <= pp_lo_q[l] + {pp_hi_q[l], 16'd0};
		end
		prod_q <= sum_q;

		meta1_q <= meta_i;
		meta2_q <= meta1_q;
		meta3_q <= meta2_q;
	end

	assign done_o = valid_q[2];
	assign result_o = prod_q;
	assign meta_o = meta3_q;

endmodule

//--- rtl/lane_alu.sv
`timescale 1ns/10ps

module lane_alu
	import exec_isa_pkg::*, exec_pipe_pkg::*;
#(
	parameter int NUM_LANES = LANES
)
(
	input alu_op_e op_i,
	input logic [NUM_LANES-1:0][WORD_W-1:0] a_i,
	input logic [NUM_LANES-1:0][WORD_W-1:0] b_i,
	output logic [NUM_LANES-1:0][WORD_W-1:0] result_o
);

	logic [NUM_LANES-1:0][WORD_W-1:0] lane_result;
	logic [NUM_LANES-1:0] lane_flag;
	logic [4:0] shamt [NUM_LANES];

	always_comb
	begin
		for (int l = 0; l < NUM_LANES; l++)
			shamt[l] = b_i[l][4:0];
	end

	always_comb
	begin
		lane_result = '0;
		lane_flag = '0;
		for (int l = 0; l < NUM_LANES; l++)
		begin
			case (op_i)
				OP_ADD:  lane_result[l] = a_i[l] + b_i[l];
				OP_SUB:  lane_result[l] = a_i[l] - b_i[l];
				OP_AND:  lane_result[l] = a_i[l] & b_i[l];
				OP_OR:   lane_result[l] = a_i[l] | b_i[l];
				OP_XOR:  lane_result[l] = a_i[l] ^ b_i[l];
				OP_SHL:  lane_result[l] = a_i[l] << shamt[l];
				OP_SHR:  lane_result[l] = a_i[l] >> shamt[l];
				OP_EQ:   lane_flag[l] = (a_i[l] == b_i[l]);
				OP_NE:   lane_flag[l] = (a_i[l] != b_i[l]);
				OP_SLT:  lane_flag[l] = ($signed(a_i[l]) < $signed(b_i[l]));
				OP_ULT:  lane_flag[l] = (a_i[l] < b_i[l]);
				OP_GE_U: lane_flag[l] = (a_i[l] >= b_i[l]);
				// MUL goes through the multiplier
				default: lane_result[l] = '0;
			endcase
		end
	end

	// Compares collapse to bit L of lane 0
	always_comb
	begin
		if (is_compare(op_i))
		begin
			result_o = '0;
			result_o[0][NUM_LANES-1:0] = lane_flag;
		end
		else
			result_o = lane_result;
	end

endmodule

//--- rtl/branch_resolve.sv
`timescale 1ns/10ps

module branch_resolve
	import exec_isa_pkg::*, exec_pipe_pkg::*;
(
	input logic valid_i,
	input issue_t issue_i,
	input lane_vec_t op1_i,
	input logic [WORD_W-1:0] alu_word_i,
	output logic taken_o,
	output logic [WORD_W-1:0] target_o,
	output logic rollback_o,
	output logic [WORD_W-1:0] rollback_pc_o
);

	logic [WORD_W-1:0] op1_word;
	logic [WORD_W-1:0] offset_ext;
	logic pc_write;
	logic all_set;

	assign op1_word = op1_i[0];
	assign offset_ext = {{(WORD_W - BR_OFFSET_W){issue_i.branch_offset[BR_OFFSET_W-1]}},
		issue_i.branch_offset};

	// ALU result written to the PC acts as a jump
	assign pc_write = issue_i.wb.has_writeback && !issue_i.wb.writeback_is_vector
		&& (issue_i.wb.writeback_reg == REG_IDX_W'(REG_PC));

	// One flag bit per lane, as produced by a coalesced compare
	assign all_set = &op1_word[LANES-1:0];

	always_comb
	begin
		if (pc_write)
		begin
			taken_o = 1'b1;
			target_o = alu_word_i;
		end
		else
		begin
			case (issue_i.branch)
				BR_ZERO:          taken_o = (op1_word == '0);
				BR_NOT_ZERO:      taken_o = (op1_word != '0);
				BR_ALL:           taken_o = all_set;
				BR_NOT_ALL:       taken_o = !all_set;
				BR_ALWAYS:        taken_o = 1'b1;
				BR_CALL_OFFSET:   taken_o = 1'b1;
				BR_CALL_REGISTER: taken_o = 1'b1;
				default:          taken_o = 1'b0;
			endcase

			if (issue_i.branch == BR_CALL_REGISTER)
				target_o = op1_word;
			else
				target_o = issue_i.pc + offset_ext;
		end
	end

	// Mispredict in either direction
	assign rollback_o = valid_i && (taken_o != issue_i.branch_predicted);
	assign rollback_pc_o = taken_o ? target_o : issue_i.pc;

endmodule

//--- rtl/operand_bypass.sv
`timescale 1ns/10ps

module operand_bypass
	import exec_isa_pkg::*, exec_pipe_pkg::*;
#(
	parameter int NUM_LANES = LANES
)
(
	input logic [REG_IDX_W-1:0] src_reg_i,
	input logic [WORD_W-1:0] pc_i,
	input logic [WORD_W-1:0] scalar_i,
	input logic [NUM_LANES-1:0][WORD_W-1:0] vector_i,
	input stage_result_t own_i,
	input bypass_t [NUM_BYPASS-1:0] bypass_i,
	input logic is_vector_i,
	output logic [WORD_W-1:0] scalar_o,
	output logic [NUM_LANES-1:0][WORD_W-1:0] vector_o
);

	localparam int NUM_WRITERS = NUM_BYPASS + 1;

	bypass_t own_writer;
	// Index 0 is the newest writer
	bypass_t [NUM_WRITERS-1:0] writers;

	function automatic logic writer_hit(wb_tag_t wb, logic [REG_IDX_W-1:0] sel,
		logic want_vector);
		return wb.has_writeback && (wb.writeback_is_vector == want_vector)
			&& (wb.writeback_reg == sel);
	endfunction

	always_comb
	begin
		own_writer.wb = own_i.wb;
		own_writer.value = own_i.result;
		own_writer.mask = own_i.mask;
	end

	assign writers = {bypass_i, own_writer};

	// Scalar read, oldest writer first so the newest one sticks
	always_comb
	begin
		scalar_o = scalar_i;
		for (int w = NUM_WRITERS - 1; w >= 0; w--)
		begin
			if (writer_hit(writers[w].wb, src_reg_i, 1'b0))
				scalar_o = writers[w].value[0];
		end

		if (src_reg_i == REG_IDX_W'(REG_PC))
			scalar_o = pc_i;
	end

	// Vector read, merged per lane by each writer's mask
	always_comb
	begin
		vector_o = vector_i;
		if (is_vector_i)
		begin
			for (int w = NUM_WRITERS - 1; w >= 0; w--)
			begin
				if (writer_hit(writers[w].wb, src_reg_i, 1'b1))
				begin
					for (int l = 0; l < NUM_LANES; l++)
					begin
						if (writers[w].mask[l])
							vector_o[l] = writers[w].value[l];
					end
				end
			end
		end
	end

endmodule

//--- rtl/exec_pipe_pkg.sv
package exec_pipe_pkg;

	import exec_isa_pkg::*;

	// Default lane count, the top level may override it
	localparam int LANES = 4;

	// Uncommitted stages after execute: memory access, writeback, post writeback
	localparam int NUM_BYPASS = 3;

	localparam int STRAND_W = 2;

	typedef logic [LANES-1:0][WORD_W-1:0] lane_vec_t;
	typedef logic [LANES-1:0] lane_mask_t;

	// Destination of a result
	typedef struct packed {
		logic has_writeback;
		logic writeback_is_vector;
		logic [REG_IDX_W-1:0] writeback_reg;
	} wb_tag_t;

	// Decoded instruction as issued by the decode stage
	typedef struct packed {
		logic [STRAND_W-1:0] strand;
		logic [WORD_W-1:0] pc;
		alu_op_e alu_op;
		branch_e branch;
		logic [BR_OFFSET_W-1:0] branch_offset;
		logic branch_predicted;
		logic op1_is_vector;
		op2_src_e op2_src;
		logic [WORD_W-1:0] immediate;
		mask_src_e mask_src;
		logic [REG_IDX_W-1:0] src1_reg;
		logic [REG_IDX_W-1:0] src2_reg;
		wb_tag_t wb;
	} issue_t;

	// One result that has not reached the register file yet
	typedef struct packed {
		wb_tag_t wb;
		lane_vec_t value;
		lane_mask_t mask;
	} bypass_t;

	// Fields that ride along the multiplier
	typedef struct packed {
		logic [STRAND_W-1:0] strand;
		logic [WORD_W-1:0] pc;
		wb_tag_t wb;
		lane_mask_t mask;
	} mul_meta_t;

	typedef struct packed {
		logic [STRAND_W-1:0] strand;
		logic [WORD_W-1:0] pc;
		wb_tag_t wb;
		lane_mask_t mask;
		lane_vec_t result;
	} stage_result_t;

endpackage

//--- rtl/exec_isa_pkg.sv
package exec_isa_pkg;

	// Register file geometry
	localparam int REG_IDX_W = 5;
	localparam int WORD_W = 32;

	// Reads as the PC; a scalar write to it is a branch
	localparam int REG_PC = 31;

	// Branch offset field width as delivered by decode
	localparam int BR_OFFSET_W = 20;

	typedef enum logic [3:0] {
		OP_ADD  = 4'd0,
		OP_SUB  = 4'd1,
		OP_AND  = 4'd2,
		OP_OR   = 4'd3,
		OP_XOR  = 4'd4,
		OP_SHL  = 4'd5,
		OP_SHR  = 4'd6,
		OP_MUL  = 4'd7,
		OP_EQ   = 4'd8,
		OP_NE   = 4'd9,
		OP_SLT  = 4'd10,
		OP_ULT  = 4'd11,
		OP_GE_U = 4'd12
	} alu_op_e;

	typedef enum logic [2:0] {
		BR_NONE          = 3'd0,
		BR_ZERO          = 3'd1,
		BR_NOT_ZERO      = 3'd2,
		BR_ALL           = 3'd3,
		BR_NOT_ALL       = 3'd4,
		BR_ALWAYS        = 3'd5,
		BR_CALL_OFFSET   = 3'd6,
		BR_CALL_REGISTER = 3'd7
	} branch_e;

	typedef enum logic [1:0] {
		OP2_SCALAR2   = 2'd0,
		OP2_VECTOR2   = 2'd1,
		OP2_IMMEDIATE = 2'd2
	} op2_src_e;

	typedef enum logic [2:0] {
		MASK_SCALAR1     = 3'd0,
		MASK_SCALAR1_INV = 3'd1,
		MASK_SCALAR2     = 3'd2,
		MASK_SCALAR2_INV = 3'd3,
		MASK_ALL_ONES    = 3'd4
	} mask_src_e;

	// Comparisons produce one bit per lane
	function automatic logic is_compare(alu_op_e op);
		return op inside {OP_EQ, OP_NE, OP_SLT, OP_ULT, OP_GE_U};
	endfunction

endpackage
